// ==== snd_params.svh ====
// Sound DAC parameters
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// PCM sample width from the host
`define SND_W 16

// Modulator input width
// One guard bit, the sample, then three zero bits
`define SND_PAD_W 20

// clk_dac cycles per pipeline clock enable
`define SND_CEN_DIV 4

// Wishbone word addresses
`define SND_ADDR_CTRL  2'd0
`define SND_ADDR_LEFT  2'd1
`define SND_ADDR_RIGHT 2'd2

`endif

// ==== snd_pkg.sv ====
// Sound DAC types
`include "snd_params.svh"

package snd_pkg;

    // Control word bit positions
    localparam int CTRL_SIGNED = 0;
    localparam int CTRL_STEREO = 1;
    localparam int CTRL_MUTE   = 2;
    localparam int CTRL_W      = 3;

    // Host PCM sample
    typedef logic [`SND_W-1:0] sample_t;

    // Padded modulator input
    typedef logic [`SND_PAD_W-1:0] pad_t;

    // Signed, stereo and mute flags
    typedef logic [CTRL_W-1:0] ctrl_t;

    // Host port
    typedef logic [1:0]  wb_addr_t;
    typedef logic [15:0] wb_data_t;

endpackage

// ==== snd_regs.sv ====
// Sound register block
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_regs (
    input  logic               clk_dac,
    input  logic               rst,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  snd_pkg::wb_addr_t  wb_adr_i,
    input  snd_pkg::wb_data_t  wb_dat_i,
    output snd_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o,
    output snd_pkg::ctrl_t     ctrl_o,
    output snd_pkg::sample_t   sample_l_o,
    output snd_pkg::sample_t   sample_r_o
);

    logic              req;
    logic              wr_en;
    snd_pkg::wb_data_t rd_data;

    // New request only while ack is low, so ack lasts one cycle
    assign req   = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en = req && wb_we_i;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    // Register file, written on the edge that raises ack
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ctrl_o     <= '0;
            sample_l_o <= '0;
            sample_r_o <= '0;
        end else if (wr_en) begin
            case (wb_adr_i)
                `SND_ADDR_CTRL: begin
                    ctrl_o <= wb_dat_i[snd_pkg::CTRL_W-1:0];
                end
                `SND_ADDR_LEFT: begin
                    sample_l_o <= wb_dat_i;
                end
                `SND_ADDR_RIGHT: begin
                    sample_r_o <= wb_dat_i;
                end
                default: begin
                    // Unmapped address drops the write
                end
            endcase
        end
    end

    // Read mux, control word zero-extended
    always_comb begin
        case (wb_adr_i)
            `SND_ADDR_CTRL:  rd_data = snd_pkg::wb_data_t'(ctrl_o);
            `SND_ADDR_LEFT:  rd_data = sample_l_o;
            `SND_ADDR_RIGHT: rd_data = sample_r_o;
            default:         rd_data = '0;
        endcase
    end

    // Read data captured with the request, valid while ack is high
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            wb_dat_o <= '0;
        end else if (req) begin
            wb_dat_o <= rd_data;
        end
    end

    // Back-to-back acks would mean a request was taken twice
    a_ack_single: assert property (
        @(posedge clk_dac) disable iff (rst)
        wb_ack_o |=> !wb_ack_o
    );

endmodule

// ==== snd_fmt.sv ====
// Sample format stage
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_fmt (
    input  logic              clk_dac,
    input  logic              rst,
    input  snd_pkg::ctrl_t    ctrl_i,
    input  snd_pkg::sample_t  sample_l_i,
    input  snd_pkg::sample_t  sample_r_i,
    output logic              cen_o,
    output snd_pkg::pad_t     pad_l_o,
    output snd_pkg::pad_t     pad_r_o
);

    localparam int LSB_PAD = `SND_PAD_W - `SND_W - 1;

    logic [`SND_CEN_DIV-1:0] ring;
    logic                    sgn;
    logic                    mute;
    logic                    stereo;
    snd_pkg::pad_t           pad_l;
    snd_pkg::pad_t           pad_r;

    // Sign flip on the top bit, then guard bit and low zeros
    function automatic snd_pkg::pad_t pad_sample(input snd_pkg::sample_t s, input logic flip);
        snd_pkg::sample_t adj;
        adj = {s[`SND_W-1] ^ flip, s[`SND_W-2:0]};
        return {1'b0, adj, {LSB_PAD{1'b0}}};
    endfunction

    // One-hot ring, cen taken from the low bit
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring <= {1'b1, {(`SND_CEN_DIV-1){1'b0}}};
        end else begin
            ring <= {ring[0], ring[`SND_CEN_DIV-1:1]};
        end
    end

    assign cen_o = ring[0];

    assign sgn    = ctrl_i[snd_pkg::CTRL_SIGNED];
    assign stereo = ctrl_i[snd_pkg::CTRL_STEREO];
    assign mute   = ctrl_i[snd_pkg::CTRL_MUTE];

    // Mono mode sends the left sample to both channels
    assign pad_l = pad_sample(sample_l_i, sgn);
    assign pad_r = stereo ? pad_sample(sample_r_i, sgn) : pad_l;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pad_l_o <= '0;
            pad_r_o <= '0;
        end else if (cen_o) begin
            pad_l_o <= mute ? '0 : pad_l;
            pad_r_o <= mute ? '0 : pad_r;
        end
    end

    a_ring_onehot: assert property (
        @(posedge clk_dac) disable iff (rst)
        $onehot(ring)
    );

endmodule

// ==== snd_sdm.sv ====
// First-order sigma-delta modulator
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_sdm (
    input  logic           clk_dac,
    input  logic           rst,
    input  logic           cen_i,
    input  snd_pkg::pad_t  pad_i,
    output logic           pwm_o
);

    localparam int ACC_W = `SND_PAD_W + 1;

    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_nxt;

    // Residue plus new input, top bit is the carry
    assign acc_nxt = {1'b0, acc[`SND_PAD_W-1:0]} + {1'b0, pad_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (cen_i) begin
            acc <= acc_nxt;
        end
    end

    // Carry held between enables
    assign pwm_o = acc[ACC_W-1];

    // Output moves only right after an enable
    a_pwm_on_cen: assert property (
        @(posedge clk_dac) disable iff (rst)
        !$stable(pwm_o) |-> $past(cen_i)
    );

endmodule

// ==== snd_dac_top.sv ====
// Sound DAC top level
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_dac_top (
    input  logic               clk_dac,
    input  logic               rst,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  snd_pkg::wb_addr_t  wb_adr_i,
    input  snd_pkg::wb_data_t  wb_dat_i,
    output snd_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o,
    output logic               snd_pwm_left_o,
    output logic               snd_pwm_right_o
);

    snd_pkg::ctrl_t   ctrl;
    snd_pkg::sample_t sample_l;
    snd_pkg::sample_t sample_r;
    logic             cen;
    snd_pkg::pad_t    pad_l;
    snd_pkg::pad_t    pad_r;
    logic             pwm_r;

    // Host registers
    snd_regs u_regs (
        .clk_dac    ( clk_dac   ),
        .rst        ( rst       ),
        .wb_cyc_i   ( wb_cyc_i  ),
        .wb_stb_i   ( wb_stb_i  ),
        .wb_we_i    ( wb_we_i   ),
        .wb_adr_i   ( wb_adr_i  ),
        .wb_dat_i   ( wb_dat_i  ),
        .wb_dat_o   ( wb_dat_o  ),
        .wb_ack_o   ( wb_ack_o  ),
        .ctrl_o     ( ctrl      ),
        .sample_l_o ( sample_l  ),
        .sample_r_o ( sample_r  )
    );

    // Clock enable and sample formatting
    snd_fmt u_fmt (
        .clk_dac    ( clk_dac   ),
        .rst        ( rst       ),
        .ctrl_i     ( ctrl      ),
        .sample_l_i ( sample_l  ),
        .sample_r_i ( sample_r  ),
        .cen_o      ( cen       ),
        .pad_l_o    ( pad_l     ),
        .pad_r_o    ( pad_r     )
    );

    snd_sdm u_sdm_l (
        .clk_dac    ( clk_dac        ),
        .rst        ( rst            ),
        .cen_i      ( cen            ),
        .pad_i      ( pad_l          ),
        .pwm_o      ( snd_pwm_left_o )
    );

    snd_sdm u_sdm_r (
        .clk_dac    ( clk_dac   ),
        .rst        ( rst       ),
        .cen_i      ( cen       ),
        .pad_i      ( pad_r     ),
        .pwm_o      ( pwm_r     )
    );

    // Mono mode mirrors the left bit stream, accumulator residues may differ
    assign snd_pwm_right_o = ctrl[snd_pkg::CTRL_STEREO] ? pwm_r : snd_pwm_left_o;

endmodule

// ==== tb_snd_dac.sv ====
// Sound DAC testbench
`timescale 1ns/1ps
`include "snd_params.svh"

module tb_snd_dac;

    localparam int CLK_PERIOD   = 40;
    localparam int RST_CYCLES   = 5;
    localparam int WIN          = 1024;
    localparam int ACK_TIMEOUT  = 16;
    localparam int EDGE_TIMEOUT = 1024 * `SND_CEN_DIV;
    localparam int SETTLE       = 3 * `SND_CEN_DIV;
    localparam int ROUNDS       = 4;
    localparam int RW_ROUNDS    = 8;

    localparam snd_pkg::wb_addr_t ADDR_NONE = 2'd3;

    logic              clk_dac;
    logic              rst;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    snd_pkg::wb_addr_t wb_adr_i;
    snd_pkg::wb_data_t wb_dat_i;
    snd_pkg::wb_data_t wb_dat_o;
    logic              wb_ack_o;
    logic              snd_pwm_left_o;
    logic              snd_pwm_right_o;

    logic [31:0] rng_state;

    // Shadow of the host registers
    snd_pkg::ctrl_t   shadow_ctrl;
    snd_pkg::sample_t shadow_l;
    snd_pkg::sample_t shadow_r;

    snd_dac_top snd_dac_top_i (
        .clk_dac         ( clk_dac         ),
        .rst             ( rst             ),
        .wb_cyc_i        ( wb_cyc_i        ),
        .wb_stb_i        ( wb_stb_i        ),
        .wb_we_i         ( wb_we_i         ),
        .wb_adr_i        ( wb_adr_i        ),
        .wb_dat_i        ( wb_dat_i        ),
        .wb_dat_o        ( wb_dat_o        ),
        .wb_ack_o        ( wb_ack_o        ),
        .snd_pwm_left_o  ( snd_pwm_left_o  ),
        .snd_pwm_right_o ( snd_pwm_right_o )
    );

    initial begin
        clk_dac = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_dac = ~clk_dac;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper LCG bits are the better ones
    function automatic snd_pkg::wb_data_t rand_word();
        logic [31:0] r;
        r = next_rand();
        return r[31:16];
    endfunction

    // Keeps some weight in bits 14..10 so either sign mode toggles the output often
    function automatic snd_pkg::sample_t rand_sample();
        snd_pkg::sample_t s;
        s = rand_word();
        if (s[14:10] == 5'd0) begin
            s[10] = 1'b1;
        end
        return s;
    endfunction

    function automatic snd_pkg::wb_data_t ctrl_word(input bit sgn, input bit stereo,
                                                    input bit mute);
        snd_pkg::wb_data_t w;
        w = '0;
        w[snd_pkg::CTRL_SIGNED] = sgn;
        w[snd_pkg::CTRL_STEREO] = stereo;
        w[snd_pkg::CTRL_MUTE]   = mute;
        return w;
    endfunction

    // Read value the host should see at an address
    function automatic snd_pkg::wb_data_t expected_read(input snd_pkg::wb_addr_t adr);
        case (adr)
            `SND_ADDR_CTRL:  return snd_pkg::wb_data_t'(shadow_ctrl);
            `SND_ADDR_LEFT:  return shadow_l;
            `SND_ADDR_RIGHT: return shadow_r;
            default:         return '0;
        endcase
    endfunction

    // Modulator input for one channel
    // Sign flip on the MSB, sample placed below a zero guard bit, three zero LSBs
    function automatic snd_pkg::pad_t expected_pad(input bit right_ch);
        snd_pkg::sample_t src;
        if (shadow_ctrl[snd_pkg::CTRL_MUTE]) begin
            return '0;
        end
        src = (right_ch && shadow_ctrl[snd_pkg::CTRL_STEREO]) ? shadow_r : shadow_l;
        if (shadow_ctrl[snd_pkg::CTRL_SIGNED]) begin
            src[`SND_W-1] = ~src[`SND_W-1];
        end
        return snd_pkg::pad_t'(src) << (`SND_PAD_W - `SND_W - 1);
    endfunction

    // Carries over a window of cen periods
    function automatic int expected_ones(input snd_pkg::pad_t pad);
        longint prod;
        prod = longint'(WIN) * longint'(pad);
        return int'(prod >> `SND_PAD_W);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input snd_pkg::wb_data_t got,
                              input snd_pkg::wb_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at time %0t: %s got 0x%04h expected 0x%04h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_density(input string name, input int got, input int exp,
                                 input int tol);
        if (got < exp - tol || got > exp + tol) begin
            stop_on_error($sformatf("Mismatch at time %0t: %s got %0d expected %0d +/- %0d",
                                    $time, name, got, exp, tol));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch at time %0t: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic wb_write(input snd_pkg::wb_addr_t adr, input snd_pkg::wb_data_t dat);
        int cnt;
        @(negedge clk_dac);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        cnt = 0;
        while (wb_ack_o !== 1'b1 && cnt < ACK_TIMEOUT) begin
            @(negedge clk_dac);
            cnt++;
        end
        if (wb_ack_o !== 1'b1) begin
            stop_on_error($sformatf("Timeout: no ack for the write to address %0d", adr));
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        case (adr)
            `SND_ADDR_CTRL:  shadow_ctrl = dat[snd_pkg::CTRL_W-1:0];
            `SND_ADDR_LEFT:  shadow_l = dat;
            `SND_ADDR_RIGHT: shadow_r = dat;
            default: ;
        endcase
    endtask

    task automatic wb_read(input snd_pkg::wb_addr_t adr, output snd_pkg::wb_data_t dat);
        int cnt;
        @(negedge clk_dac);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        cnt = 0;
        while (wb_ack_o !== 1'b1 && cnt < ACK_TIMEOUT) begin
            @(negedge clk_dac);
            cnt++;
        end
        if (wb_ack_o !== 1'b1) begin
            stop_on_error($sformatf("Timeout: no ack for the read from address %0d", adr));
        end
        dat = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    // Settle, align to an output change, then one sample per cen period
    task automatic measure_window(input bit mono, output int ones_l, output int ones_r);
        logic prev_l;
        logic prev_r;
        int   cnt;
        int   i;
        bit   found;
        repeat (SETTLE) @(negedge clk_dac);
        prev_l = snd_pwm_left_o;
        prev_r = snd_pwm_right_o;
        found  = 1'b0;
        cnt    = 0;
        while (!found && cnt < EDGE_TIMEOUT) begin
            @(negedge clk_dac);
            cnt++;
            if (snd_pwm_left_o !== prev_l || snd_pwm_right_o !== prev_r) begin
                found = 1'b1;
            end
            prev_l = snd_pwm_left_o;
            prev_r = snd_pwm_right_o;
        end
        if (!found) begin
            stop_on_error("Timeout: the pwm outputs never changed while aligning the window");
        end
        ones_l = 0;
        ones_r = 0;
        for (i = 0; i < WIN; i++) begin
            if (i != 0) begin
                repeat (`SND_CEN_DIV) @(negedge clk_dac);
            end
            if (mono) begin
                check_bit("snd_pwm_right_o", snd_pwm_right_o, snd_pwm_left_o);
            end
            if (snd_pwm_left_o === 1'b1) begin
                ones_l++;
            end
            if (snd_pwm_right_o === 1'b1) begin
                ones_r++;
            end
        end
    endtask

    task automatic check_channels(input bit mono);
        int ones_l;
        int ones_r;
        measure_window(mono, ones_l, ones_r);
        check_density("snd_pwm_left_o ones", ones_l, expected_ones(expected_pad(1'b0)), 1);
        check_density("snd_pwm_right_o ones", ones_r, expected_ones(expected_pad(1'b1)), 1);
    endtask

    task automatic check_mute_window();
        int i;
        repeat (SETTLE) @(negedge clk_dac);
        for (i = 0; i < WIN * `SND_CEN_DIV; i++) begin
            @(negedge clk_dac);
            check_bit("snd_pwm_left_o", snd_pwm_left_o, 1'b0);
            check_bit("snd_pwm_right_o", snd_pwm_right_o, 1'b0);
        end
    endtask

    initial begin
        snd_pkg::wb_data_t rd;
        snd_pkg::wb_addr_t adr;
        int                a;
        int                n;
        rng_state   = 32'd49;
        shadow_ctrl = '0;
        shadow_l    = '0;
        shadow_r    = '0;
        rst      = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (RST_CYCLES) @(negedge clk_dac);
        rst = 1'b0;

        // Reset state
        @(negedge clk_dac);
        check_bit("wb_ack_o", wb_ack_o, 1'b0);
        check_bit("snd_pwm_left_o", snd_pwm_left_o, 1'b0);
        check_bit("snd_pwm_right_o", snd_pwm_right_o, 1'b0);
        for (a = 0; a < 3; a++) begin
            adr = snd_pkg::wb_addr_t'(a);
            wb_read(adr, rd);
            check_data($sformatf("wb_dat_o addr %0d", a), rd, 16'h0000);
        end

        // Register readback, unmapped address included
        for (n = 0; n < RW_ROUNDS; n++) begin
            wb_write(`SND_ADDR_CTRL, rand_word());
            wb_write(`SND_ADDR_LEFT, rand_word());
            wb_write(`SND_ADDR_RIGHT, rand_word());
            wb_write(ADDR_NONE, rand_word());
            for (a = 0; a < 4; a++) begin
                adr = snd_pkg::wb_addr_t'(a);
                wb_read(adr, rd);
                check_data($sformatf("wb_dat_o addr %0d", a), rd, expected_read(adr));
            end
        end

        // Stereo density, unsigned then signed on the same samples
        for (n = 0; n < ROUNDS; n++) begin
            wb_write(`SND_ADDR_LEFT, rand_sample());
            wb_write(`SND_ADDR_RIGHT, rand_sample());
            wb_write(`SND_ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b0));
            check_channels(1'b0);
            wb_write(`SND_ADDR_CTRL, ctrl_word(1'b1, 1'b1, 1'b0));
            check_channels(1'b0);
        end

        // Mono mirroring ignores the right register
        for (n = 0; n < 2; n++) begin
            wb_write(`SND_ADDR_LEFT, rand_sample());
            wb_write(`SND_ADDR_RIGHT, rand_sample());
            wb_write(`SND_ADDR_CTRL, ctrl_word(n[0], 1'b0, 1'b0));
            check_channels(1'b1);
        end

        // Mute in both channel modes
        wb_write(`SND_ADDR_CTRL, ctrl_word(1'b0, 1'b1, 1'b1));
        check_mute_window();
        wb_write(`SND_ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b1));
        check_mute_window();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
snd_pkg.sv
snd_regs.sv
snd_fmt.sv
snd_sdm.sv
snd_dac_top.sv
tb_snd_dac.sv

// ==== Makefile ====
# Verilator build and run for the sound DAC testbench

VERILATOR ?= verilator
TOP       ?= tb_snd_dac
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST)) snd_params.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "No result found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
